// ==== periph_gpio_defines.svh ====
// Shared widths, GPIO register offsets and synchronizer depth, included by the GPIO RTL files
`ifndef PERIPH_GPIO_DEFINES_SVH
`define PERIPH_GPIO_DEFINES_SVH

// Peripheral byte address width seen on the strobe bus
// Covers the whole GPIO register window
`define PERIPH_ADDR_W 8

// Number of GPIO pins
`define GPIO_W 16

// Word offsets of the GPIO registers
// Output data, read and write
`define GPIO_OFS_DATA_OUT 8'h00
// Direction, 1 drives the pin
`define GPIO_OFS_DIR 8'h04
// Synchronized pin inputs, read only
`define GPIO_OFS_DATA_IN 8'h08
// Set and clear masks, write only
`define GPIO_OFS_SET_CLR 8'h0C

// Flop depth of the pin input synchronizer
// Two stages give the usual metastability margin
`define GPIO_SYNC_STAGES 2

`endif

// ==== periph_gpio_pkg.sv ====
// Types for the AHB GPIO peripheral, imported by the bridge, the register file and the testbench
package periph_gpio_pkg;

   // AHB transfer sizes used on a 32-bit port
   // Larger encodings never reach this slave
   typedef enum logic [2:0] {
      HSIZE_BYTE = 3'b000,
      HSIZE_HALF = 3'b001,
      HSIZE_WORD = 3'b010
   } hsize_e;

   // Set/clear word split into its two masks
   // Upper half clears pins, lower half sets them
   typedef struct packed {
      logic [15:0] clr;
      logic [15:0] set;
   } gpio_set_clr_s;

   // The same bus word seen raw or as the two masks
   typedef union packed {
      logic [31:0]   raw;
      gpio_set_clr_s mask;
   } gpio_set_clr_u;

endpackage

// ==== periph_ahb_bridge.sv ====
// AHB-Lite to strobe bus bridge: registers the address phase into bus_en, bus_addr and bus_bytesel
`include "periph_gpio_defines.svh"

module periph_ahb_bridge
   import periph_gpio_pkg::*;
(
   input  logic                      clk_in,
   input  logic                      rst_n,
   // AHB-Lite address phase
   input  logic [31:0]               haddr,
   input  logic                      hwrite,
   input  hsize_e                    hsize,
   input  logic [1:0]                htrans,
   input  logic                      hsel,
   input  logic                      hreadyin,
   // AHB-Lite data phase
   input  logic [31:0]               hwdata,
   // Strobe bus towards the register file
   output logic                      bus_en,
   output logic [`PERIPH_ADDR_W-1:0] bus_addr,
   output logic [3:0]                bus_bytesel,
   output logic [31:0]               bus_wdata
);

   // Byte lanes of the current address phase
   logic [3:0] lanes;
   // NONSEQ or SEQ to this slave
   logic       active;
   // Active transfer that writes
   logic       active_wr;

   // htrans bit 1 separates NONSEQ/SEQ from IDLE/BUSY
   assign active    = hsel & htrans[1];
   assign active_wr = active & hwrite;

   // Lane decode from size and low address bits
   always_comb begin
      lanes = 4'b0000;
      case (hsize)
         HSIZE_WORD: begin
            lanes = 4'b1111;
         end
         HSIZE_HALF: begin
            // Bit 1 picks the low or high halfword
            if (haddr[1]) begin
               lanes = 4'b1100;
            end else begin
               lanes = 4'b0011;
            end
         end
         HSIZE_BYTE: begin
            // One-hot lane from the byte offset
            lanes = 4'b0001 << haddr[1:0];
         end
         default: begin
            // Sizes above a word are not supported
            lanes = 4'b0000;
         end
      endcase
   end

   // Address phase capture
   // Only when hreadyin is high, so the data phase of a stalled
   // transfer keeps its strobes
   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         bus_en      <= 1'b0;
         bus_addr    <= '0;
         bus_bytesel <= 4'b0000;
      end else if (hreadyin) begin
         bus_en      <= active;
         // Idle cycles leave a zero address behind
         bus_addr    <= haddr[`PERIPH_ADDR_W-1:0] & {`PERIPH_ADDR_W{active}};
         // Reads carry no lanes, the register file uses that to tell them apart
         bus_bytesel <= lanes & {4{active_wr}};
      end
   end

   // Write data already belongs to the data phase
   assign bus_wdata = hwdata;

endmodule

// ==== periph_gpio_regs.sv ====
// GPIO register file for the strobe bus, instantiated by the top level between bridge and pins
`include "periph_gpio_defines.svh"

module periph_gpio_regs
   import periph_gpio_pkg::*;
(
   input  logic                      clk_in,
   input  logic                      rst_n,
   // Strobe bus from the bridge
   input  logic                      bus_en,
   input  logic [`PERIPH_ADDR_W-1:0] bus_addr,
   input  logic [3:0]                bus_bytesel,
   input  logic [31:0]               bus_wdata,
   // Synchronized pins from the pin stage
   input  logic [`GPIO_W-1:0]        pin_sync,
   // Read return to the bridge side
   output logic [31:0]               bus_rdata,
   output logic                      bus_ready,
   // Register values to the pin stage
   output logic [`GPIO_W-1:0]        out_data,
   output logic [`GPIO_W-1:0]        out_dir
);

   // Offset with the byte bits cleared
   logic [`PERIPH_ADDR_W-1:0] word_addr;
   // Register hits
   logic                      hit_data_out;
   logic                      hit_dir;
   logic                      hit_data_in;
   logic                      hit_set_clr;
   // Bytesel expanded to bit enables
   logic [31:0]               lane_mask;
   // Write data with disabled lanes zeroed
   logic [31:0]               wdata_masked;
   // Set/clear view of the masked write word
   gpio_set_clr_u             set_clr;
   // Write and read qualifiers
   logic                      wr_en;
   logic                      rd_first;
   // High in the second cycle of a read
   logic                      rd_wait;
   // Read mux output
   logic [31:0]               rdata_nxt;

   assign word_addr = {bus_addr[`PERIPH_ADDR_W-1:2], 2'b00};

   assign hit_data_out = (word_addr == `GPIO_OFS_DATA_OUT);
   assign hit_dir      = (word_addr == `GPIO_OFS_DIR);
   assign hit_data_in  = (word_addr == `GPIO_OFS_DATA_IN);
   assign hit_set_clr  = (word_addr == `GPIO_OFS_SET_CLR);

   assign lane_mask = {{8{bus_bytesel[3]}}, {8{bus_bytesel[2]}},
                       {8{bus_bytesel[1]}}, {8{bus_bytesel[0]}}};
   assign wdata_masked = bus_wdata & lane_mask;

   // Masks of disabled lanes come out as zero
   assign set_clr.raw = wdata_masked;

   // Bytesel is only nonzero for writes
   assign wr_en = bus_en & (|bus_bytesel);

   // First cycle of a read data phase
   assign rd_first = bus_en & ~(|bus_bytesel) & ~rd_wait;

   // Writes never stall and reads stall once
   assign bus_ready = ~rd_first;

   // Output data by lane or through set/clear
   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         out_data <= '0;
      end else if (wr_en && hit_data_out) begin
         out_data <= (out_data & ~lane_mask[`GPIO_W-1:0]) | wdata_masked[`GPIO_W-1:0];
      end else if (wr_en && hit_set_clr) begin
         // Set is applied last so it wins over clear
         out_data <= (out_data & ~set_clr.mask.clr) | set_clr.mask.set;
      end
   end

   // Direction register written by byte lane only
   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         out_dir <= '0;
      end else if (wr_en && hit_dir) begin
         out_dir <= (out_dir & ~lane_mask[`GPIO_W-1:0]) | wdata_masked[`GPIO_W-1:0];
      end
   end

   // Read mux with the upper bits left at zero
   always_comb begin
      rdata_nxt = 32'h0000_0000;
      if (hit_data_out) begin
         rdata_nxt[`GPIO_W-1:0] = out_data;
      end else if (hit_dir) begin
         rdata_nxt[`GPIO_W-1:0] = out_dir;
      end else if (hit_data_in) begin
         rdata_nxt[`GPIO_W-1:0] = pin_sync;
      end
      // SET_CLR and unmapped offsets read as zero
   end

   // Wait state flag
   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         rd_wait <= 1'b0;
      end else begin
         rd_wait <= rd_first;
      end
   end

   // Read data captured at the end of the wait cycle
   // and held until the next read
   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         bus_rdata <= 32'h0000_0000;
      end else if (rd_first) begin
         bus_rdata <= rdata_nxt;
      end
   end

endmodule

// ==== periph_gpio_pins.sv ====
// GPIO pin stage: registers pin drive and output enables and synchronizes the pin inputs
`include "periph_gpio_defines.svh"

module periph_gpio_pins (
   input  logic               clk_in,
   input  logic               rst_n,
   // Register values from the register file
   input  logic [`GPIO_W-1:0] out_data,
   input  logic [`GPIO_W-1:0] out_dir,
   // Raw pad inputs, asynchronous to clk_in
   input  logic [`GPIO_W-1:0] gpio_in,
   // Synchronized inputs back to the register file
   output logic [`GPIO_W-1:0] pin_sync,
   // Pad drive
   output logic [`GPIO_W-1:0] gpio_out,
   output logic [`GPIO_W-1:0] gpio_oe
);

   // Synchronizer chain, stage 0 samples the pads
   logic [`GPIO_W-1:0] sync_q [`GPIO_SYNC_STAGES];

   // Output flops
   // Pins that are inputs get a zero drive value
   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         gpio_oe  <= '0;
         gpio_out <= '0;
      end else begin
         gpio_oe  <= out_dir;
         gpio_out <= out_data & out_dir;
      end
   end

   // Input synchronizer
   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `GPIO_SYNC_STAGES; i++) begin
            sync_q[i] <= '0;
         end
      end else begin
         sync_q[0] <= gpio_in;
         // Shift each stage one step down the chain
         for (int i = 1; i < `GPIO_SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   // Last stage is the only safe one to use
   assign pin_sync = sync_q[`GPIO_SYNC_STAGES-1];

endmodule

// ==== periph_gpio_top.sv ====
// GPIO peripheral top level: AHB-Lite slave port and GPIO pads, instantiated by the SoC
`include "periph_gpio_defines.svh"

module periph_gpio_top
   import periph_gpio_pkg::*;
(
   input  logic               clk_in,
   input  logic               rst_n,
   // AHB-Lite slave port
   input  logic [31:0]        haddr,
   input  logic               hwrite,
   input  hsize_e             hsize,
   input  logic [1:0]         htrans,
   input  logic [31:0]        hwdata,
   input  logic               hsel,
   input  logic               hreadyin,
   output logic [31:0]        hrdata,
   output logic               hreadyout,
   // GPIO pads
   input  logic [`GPIO_W-1:0] gpio_in,
   output logic [`GPIO_W-1:0] gpio_out,
   output logic [`GPIO_W-1:0] gpio_oe
);

   // Strobe bus
   logic                      bus_en;
   logic [`PERIPH_ADDR_W-1:0] bus_addr;
   logic [3:0]                bus_bytesel;
   logic [31:0]               bus_wdata;
   // Register file to pin stage and back
   logic [`GPIO_W-1:0]        out_data;
   logic [`GPIO_W-1:0]        out_dir;
   logic [`GPIO_W-1:0]        pin_sync;

   periph_ahb_bridge u_bridge (
      .clk_in      (clk_in),
      .rst_n       (rst_n),
      .haddr       (haddr),
      .hwrite      (hwrite),
      .hsize       (hsize),
      .htrans      (htrans),
      .hsel        (hsel),
      .hreadyin    (hreadyin),
      .hwdata      (hwdata),
      .bus_en      (bus_en),
      .bus_addr    (bus_addr),
      .bus_bytesel (bus_bytesel),
      .bus_wdata   (bus_wdata)
   );

   // Read data and ready go straight back onto the AHB port
   periph_gpio_regs u_regs (
      .clk_in      (clk_in),
      .rst_n       (rst_n),
      .bus_en      (bus_en),
      .bus_addr    (bus_addr),
      .bus_bytesel (bus_bytesel),
      .bus_wdata   (bus_wdata),
      .pin_sync    (pin_sync),
      .bus_rdata   (hrdata),
      .bus_ready   (hreadyout),
      .out_data    (out_data),
      .out_dir     (out_dir)
   );

   periph_gpio_pins u_pins (
      .clk_in   (clk_in),
      .rst_n    (rst_n),
      .out_data (out_data),
      .out_dir  (out_dir),
      .gpio_in  (gpio_in),
      .pin_sync (pin_sync),
      .gpio_out (gpio_out),
      .gpio_oe  (gpio_oe)
   );

endmodule

// ==== periph_gpio_asserts.sv ====
// Protocol checks bound into the GPIO peripheral top level during simulation
`include "periph_gpio_defines.svh"

module periph_gpio_asserts (
   input logic               clk_in,
   input logic               rst_n,
   // Strobe bus between bridge and register file
   input logic               bus_en,
   input logic [3:0]         bus_bytesel,
   // AHB ready towards the master
   input logic               hreadyout,
   // Pad drive
   input logic [`GPIO_W-1:0] gpio_out,
   input logic [`GPIO_W-1:0] gpio_oe
);

   // No byte lanes outside a data phase
   a_bytesel_idle: assert property (@(posedge clk_in) disable iff (!rst_n)
      !bus_en |-> (bus_bytesel == 4'b0000))
      else $error("bus_bytesel has lanes set while bus_en is low");

   // A read stalls for one cycle only
   a_single_wait: assert property (@(posedge clk_in) disable iff (!rst_n)
      !hreadyout |=> hreadyout)
      else $error("hreadyout stayed low after a read wait state");

   // Input pins are never driven high
   a_out_gated: assert property (@(posedge clk_in) disable iff (!rst_n)
      (gpio_out & ~gpio_oe) == '0)
      else $error("gpio_out is high on a pin whose gpio_oe is low");

endmodule

bind periph_gpio_top periph_gpio_asserts u_asserts (
   .clk_in      (clk_in),
   .rst_n       (rst_n),
   .bus_en      (bus_en),
   .bus_bytesel (bus_bytesel),
   .hreadyout   (hreadyout),
   .gpio_out    (gpio_out),
   .gpio_oe     (gpio_oe)
);

// ==== tb_periph_gpio.sv ====
// Testbench that replays the GPIO pattern file as AHB transfers and pad events against the top level
`include "periph_gpio_defines.svh"

module tb_periph_gpio
   import periph_gpio_pkg::*;
();

   logic               clk_in = 1'b0;
   logic               rst_n;
   // AHB master side
   logic [31:0]        haddr;
   logic               hwrite;
   hsize_e             hsize;
   logic [1:0]         htrans;
   logic [31:0]        hwdata;
   logic               hsel;
   logic               hreadyin;
   logic [31:0]        hrdata;
   logic               hreadyout;
   // Pads
   logic [`GPIO_W-1:0] gpio_in;
   logic [`GPIO_W-1:0] gpio_out;
   logic [`GPIO_W-1:0] gpio_oe;

   // Pattern columns, one entry per file line
   logic [31:0] pat_test [$];
   logic [31:0] pat_op   [$];
   logic [31:0] pat_addr [$];
   logic [31:0] pat_size [$];
   logic [31:0] pat_data [$];
   logic [31:0] pat_exp  [$];

   // Transfer whose data phase is still open
   logic        pend_valid;
   logic        pend_read;
   logic [31:0] pend_exp;

   int cycle_cnt = 0;
   int cycle_limit = 10;
   int err_total;
   int check_total;
   int test_errs;
   int test_checks;
   int test_cnt;

   periph_gpio_top UUT (
      .clk_in    (clk_in),
      .rst_n     (rst_n),
      .haddr     (haddr),
      .hwrite    (hwrite),
      .hsize     (hsize),
      .htrans    (htrans),
      .hwdata    (hwdata),
      .hsel      (hsel),
      .hreadyin  (hreadyin),
      .hrdata    (hrdata),
      .hreadyout (hreadyout),
      .gpio_in   (gpio_in),
      .gpio_out  (gpio_out),
      .gpio_oe   (gpio_oe)
   );

   // One slave only, so its ready loops straight back
   assign hreadyin = hreadyout;

   always #4 clk_in = ~clk_in;

   // Run limit in clock cycles
   always @(posedge clk_in) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
         $display("Timeout after %0d cycles, the DUT stopped completing transfers", cycle_cnt);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      test_checks++;
      assert (act == exp) else begin
         $display("[ERROR] %0t: %s expected %08h, actual %08h", $time, name, exp, act);
         test_errs++;
      end
   endtask

   // Present one address phase and close the data phase in flight
   // Entered and left just after a rising edge
   task automatic bus_phase(input logic act, input logic wr, input logic [31:0] addr,
                            input logic [31:0] size, input logic [31:0] data,
                            input logic [31:0] exp);
      int low_cnt;
      low_cnt = 0;
      haddr  <= addr;
      hwrite <= wr;
      hsize  <= hsize_e'(size[2:0]);
      htrans <= act ? 2'b10 : 2'b00;
      hsel   <= act;
      // Count stalled cycles of the open data phase
      @(negedge clk_in);
      while (!hreadyout) begin
         low_cnt++;
         @(negedge clk_in);
      end
      if (pend_valid) begin
         if (pend_read) begin
            check_value("hrdata", pend_exp, hrdata);
            check_value("hreadyout low cycles", 32'd1, low_cnt);
         end else begin
            check_value("hreadyout low cycles", 32'd0, low_cnt);
         end
      end
      // New address phase taken here
      @(posedge clk_in);
      hwdata     <= (act && wr) ? data : 32'h0000_0000;
      pend_valid = act;
      pend_read  = act & ~wr;
      pend_exp   = exp;
   endtask

   task automatic bus_idle();
      bus_phase(1'b0, 1'b0, 32'h0, 32'h2, 32'h0, 32'h0);
   endtask

   // Pad step, either new gpio_in and a gpio_out check or a gpio_oe check
   task automatic pad_step(input logic set_pins, input logic [31:0] data,
                           input logic [31:0] exp);
      bus_idle();
      if (set_pins) begin
         gpio_in <= data[`GPIO_W-1:0];
      end
      // Enough for the output flops and the synchronizer
      repeat (3) @(posedge clk_in);
      @(negedge clk_in);
      if (set_pins) begin
         check_value("gpio_out", exp, 32'(gpio_out));
      end else begin
         check_value("gpio_oe", exp, 32'(gpio_oe));
      end
      @(posedge clk_in);
   endtask

   task automatic finish_test(input logic [31:0] num);
      bus_idle();
      $display("Test %0d finished with %0d checks and %0d errors", num, test_checks, test_errs);
      test_cnt++;
      check_total += test_checks;
      err_total   += test_errs;
      test_checks = 0;
      test_errs   = 0;
   endtask

   task automatic load_patterns();
      int          fd;
      int          n;
      string       line;
      logic [31:0] f_test, f_op, f_addr, f_size, f_data, f_exp;
      fd = $fopen("periph_gpio_patterns.txt", "r");
      if (fd == 0) begin
         $display("Pattern file periph_gpio_patterns.txt could not be opened");
         err_total++;
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            // Comment lines do not scan as six hex fields
            if (n > 0 && $sscanf(line, "%h %h %h %h %h %h",
                                 f_test, f_op, f_addr, f_size, f_data, f_exp) == 6) begin
               pat_test.push_back(f_test);
               pat_op.push_back(f_op);
               pat_addr.push_back(f_addr);
               pat_size.push_back(f_size);
               pat_data.push_back(f_data);
               pat_exp.push_back(f_exp);
            end
         end
         $fclose(fd);
      end
   endtask

   initial begin
      int          idx;
      logic [31:0] cur_test;
      rst_n       = 1'b0;
      haddr       = 32'h0000_0000;
      hwrite      = 1'b0;
      hsize       = HSIZE_WORD;
      htrans      = 2'b00;
      hwdata      = 32'h0000_0000;
      hsel        = 1'b0;
      gpio_in     = '0;
      pend_valid  = 1'b0;
      pend_read   = 1'b0;
      pend_exp    = 32'h0000_0000;
      err_total   = 0;
      check_total = 0;
      test_errs   = 0;
      test_checks = 0;
      test_cnt    = 0;
      cur_test    = 32'h0000_0000;
      load_patterns();
      if (pat_op.size() == 0) begin
         $display("No transfers were found in the pattern file");
         err_total++;
      end
      cycle_limit = 8 * pat_op.size() + 10;
      repeat (10) @(posedge clk_in);
      rst_n <= 1'b1;
      for (idx = 0; idx < pat_op.size(); idx++) begin
         // Close the previous test when the number changes
         if (idx > 0 && pat_test[idx] != cur_test) begin
            finish_test(cur_test);
         end
         cur_test = pat_test[idx];
         case (pat_op[idx])
            32'h0: bus_phase(1'b1, 1'b1, pat_addr[idx], pat_size[idx], pat_data[idx], 32'h0);
            32'h1: bus_phase(1'b1, 1'b0, pat_addr[idx], pat_size[idx], 32'h0, pat_exp[idx]);
            32'h2: pad_step(1'b1, pat_data[idx], pat_exp[idx]);
            32'h3: pad_step(1'b0, 32'h0, pat_exp[idx]);
            default: begin
               $display("Pattern line %0d holds an unknown operation %0h", idx, pat_op[idx]);
               test_errs++;
            end
         endcase
      end
      if (pat_op.size() > 0) begin
         finish_test(cur_test);
      end
      $display("Totals: %0d tests, %0d checks, %0d errors", test_cnt, check_total, err_total);
      if (err_total == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== periph_gpio_patterns.txt ====
// test op addr size data expect, all hex, one transfer per line
// op 0 write, 1 read, 2 set gpio_in and check gpio_out, 3 check gpio_oe; size 0 byte, 1 half, 2 word
1 1 00 2 00000000 00000000
1 1 04 2 00000000 00000000
1 1 08 2 00000000 00000000
1 2 00 0 00000000 00000000
1 3 00 0 00000000 00000000
2 0 00 2 0000C3C3 00000000
2 0 04 2 000000FF 00000000
2 1 00 2 00000000 0000C3C3
2 1 04 2 00000000 000000FF
2 2 00 0 00000000 000000C3
2 3 00 0 00000000 000000FF
3 0 01 0 00005A00 00000000
3 1 00 2 00000000 00005AC3
3 0 06 1 12340000 00000000
3 1 04 2 00000000 000000FF
3 0 04 1 0000F00F 00000000
3 1 04 2 00000000 0000F00F
3 0 00 2 FFFF1234 00000000
3 1 00 2 00000000 00001234
3 0 03 0 77000000 00000000
3 1 00 2 00000000 00001234
3 2 00 0 00000000 00001004
3 3 00 0 00000000 0000F00F
4 0 0C 2 00340F00 00000000
4 1 00 2 00000000 00001F00
4 0 0C 2 FFFF00A5 00000000
4 1 00 2 00000000 000000A5
4 0 0C 2 00F000F0 00000000
4 1 00 2 00000000 000000F5
4 0 0C 1 FFFF0F00 00000000
4 1 00 2 00000000 00000FF5
4 0 0E 1 00FF3000 00000000
4 1 00 2 00000000 00000F00
4 1 0C 2 00000000 00000000
4 2 00 0 00000000 00000000
5 2 00 0 0000BEEF 00000000
5 1 08 2 00000000 0000BEEF
5 0 04 2 0000FFFF 00000000
5 2 00 0 00001357 00000F00
5 1 08 2 00000000 00001357
6 0 00 2 0000ABCD 00000000
6 1 00 2 00000000 0000ABCD
6 0 04 2 00000F0F 00000000
6 1 04 2 00000000 00000F0F
6 0 0C 2 00010002 00000000
6 1 00 2 00000000 0000ABCE
6 1 04 2 00000000 00000F0F
6 2 00 0 00000000 00000B0E

// ==== periph_gpio.f ====
+incdir+.
periph_gpio_pkg.sv
periph_ahb_bridge.sv
periph_gpio_regs.sv
periph_gpio_pins.sv
periph_gpio_top.sv
periph_gpio_asserts.sv
tb_periph_gpio.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the GPIO peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f periph_gpio.f --top-module tb_periph_gpio \
   -Mdir obj_dir -o sim_periph_gpio
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_periph_gpio > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
   exit 1
fi
if ! grep -q "Simulation completed successfully" "$LOG"; then
   echo "Simulation log has no result line"
   exit 1
fi
exit 0
